/* design/dft_mem_pkg.sv */
/*
 * Shared definitions for the in-place radix-2 DFT engine
 * Sample and twiddle widths, address sizing, engine states
 * and the 16-point Q1.14 twiddle table
 */

package dft_mem_pkg;

	// Real or imaginary part, two's complement
	localparam int D_W = 16;
	// Largest transform is 16 points
	localparam int N_LOG2_MAX = 4;
	localparam int A_W = N_LOG2_MAX;
	// Twiddle coefficients in Q1.14
	localparam int TW_W = 16;

	typedef enum logic [2:0]
	{
		IDLE        = 3'd0,
		SINK        = 3'd1,
		RD          = 3'd2,
		WAIT_WR_END = 3'd3,
		SOURCE      = 3'd4
	} engine_state_t;

	// cos(2*pi*k/16), k in 0..7
	function automatic logic signed [TW_W-1:0] twiddle_cos(input logic [A_W-2:0] k);
		case (k)
			3'd0: twiddle_cos = 16'sd16384;
			3'd1: twiddle_cos = 16'sd15137;
			3'd2: twiddle_cos = 16'sd11585;
			3'd3: twiddle_cos = 16'sd6270;
			3'd4: twiddle_cos = 16'sd0;
			3'd5: twiddle_cos = -16'sd6270;
			3'd6: twiddle_cos = -16'sd11585;
			default: twiddle_cos = -16'sd15137;
		endcase
	endfunction

	// sin(2*pi*k/16), k in 0..7
	function automatic logic signed [TW_W-1:0] twiddle_sin(input logic [A_W-2:0] k);
		case (k)
			3'd0: twiddle_sin = 16'sd0;
			3'd1: twiddle_sin = 16'sd6270;
			3'd2: twiddle_sin = 16'sd11585;
			3'd3: twiddle_sin = 16'sd15137;
			3'd4: twiddle_sin = 16'sd16384;
			3'd5: twiddle_sin = 16'sd15137;
			3'd6: twiddle_sin = 16'sd11585;
			default: twiddle_sin = 16'sd6270;
		endcase
	endfunction

endpackage

/* design/dft_bank_ram.sv */
/*
 * Complex sample memory for the DFT engine
 * One write port and one read port, read data registered
 * and valid one cycle after rd_en
 */

`timescale 1ns/1ns

module dft_bank_ram (
	input  logic                          clk,
	input  logic                          wr_en,
	input  logic [dft_mem_pkg::A_W-1:0]   wr_addr,
	input  logic [dft_mem_pkg::D_W-1:0]   wr_re,
	input  logic [dft_mem_pkg::D_W-1:0]   wr_im,
	input  logic                          rd_en,
	input  logic [dft_mem_pkg::A_W-1:0]   rd_addr,
	output logic [dft_mem_pkg::D_W-1:0]   rd_re,
	output logic [dft_mem_pkg::D_W-1:0]   rd_im
);
	import dft_mem_pkg::*;

	// Separate real and imaginary arrays, full 16-word depth
	logic [D_W-1:0] mem_re [2**A_W];
	logic [D_W-1:0] mem_im [2**A_W];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem_re[wr_addr] <= wr_re;
			mem_im[wr_addr] <= wr_im;
		end
	end

	// Registered read, holds last word when idle
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_re <= mem_re[rd_addr];
			rd_im <= mem_im[rd_addr];
		end
	end

	// In-place schedule never reads and writes one word together
	a_no_rw_collision: assert property (@(posedge clk)
		!(wr_en && rd_en && (wr_addr == rd_addr)));

endmodule

/* design/dft_mem_sink.sv */
/*
 * Input sink of the DFT engine
 * Takes one frame of N samples and writes each one at the
 * bit-reversed value of its index
 * sink_done marks the Nth sample
 */

`timescale 1ns/1ns

module dft_mem_sink #(
	parameter int N_LOG2 = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          active,
	input  logic                          in_sop,
	input  logic                          in_valid,
	input  logic [dft_mem_pkg::D_W-1:0]   in_re,
	input  logic [dft_mem_pkg::D_W-1:0]   in_im,
	output logic                          wr_en,
	output logic [dft_mem_pkg::A_W-1:0]   wr_addr,
	output logic [dft_mem_pkg::D_W-1:0]   wr_re,
	output logic [dft_mem_pkg::D_W-1:0]   wr_im,
	output logic                          sink_done
);
	import dft_mem_pkg::*;

	localparam int N = 1 << N_LOG2;

	logic           started;
	logic           take;
	// Sample index within the frame
	logic [A_W-1:0] cnt;
	logic [A_W-1:0] rev;

	// Only the first sample needs in_sop
	assign take = active && in_valid && (started || in_sop);

	// Bit reversal over N_LOG2 bits only
	always_comb
	begin
		rev = '0;
		for (int i = 0; i < N_LOG2; i++)
			rev[i] = cnt[N_LOG2-1-i];
	end

	// Write goes out in the same cycle the sample is taken
	assign wr_en     = take;
	assign wr_addr   = rev;
	assign wr_re     = in_re;
	assign wr_im     = in_im;
	assign sink_done = take && (cnt == A_W'(N-1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			started <= 1'b0;
			cnt     <= '0;
		end
		else if (sink_done)
		begin
			started <= 1'b0;
			cnt     <= '0;
		end
		else if (take)
		begin
			started <= 1'b1;
			cnt     <= cnt + 1'b1;
		end
	end

	// Count is clear whenever the sink is not active
	a_cnt_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		!active |-> (cnt == '0));

endmodule

/* design/dft_stage_read.sv */
/*
 * Read stage of one radix-2 butterfly pass
 * Issues N reads back to back, top then bottom word of each
 * butterfly, with the twiddle index on the 16-point table
 */

`timescale 1ns/1ns

module dft_stage_read #(
	parameter int N_LOG2 = 3
) (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  dft_mem_pkg::engine_state_t                    state,
	input  logic [$clog2(dft_mem_pkg::N_LOG2_MAX)-1:0]    stage,
	output logic                                          rd_en,
	output logic [dft_mem_pkg::A_W-1:0]                   rd_addr,
	output logic                                          pair_valid,
	output logic [dft_mem_pkg::A_W-1:0]                   pair_addr,
	output logic [dft_mem_pkg::A_W-2:0]                   tw_index,
	output logic                                          rd_end
);
	import dft_mem_pkg::*;

	localparam int N = 1 << N_LOG2;

	logic [A_W-1:0] cnt;
	// Butterfly number within the stage
	logic [A_W-1:0] bf;
	// Half span of the stage, 2^stage
	logic [A_W-1:0] half;
	// Position inside the group
	logic [A_W-1:0] pos;
	logic [A_W-1:0] top;
	logic [A_W-1:0] tw_full;

	// Word counter, runs only in RD
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (state == RD)
			cnt <= cnt + 1'b1;
		else
			cnt <= '0;
	end

	//----------------------------------------------------------------------
	// Address generation
	//----------------------------------------------------------------------
	// Two words per butterfly
	assign bf   = cnt >> 1;
	assign half = A_W'(1) << stage;
	assign pos  = bf & (half - 1'b1);
	// Group base is group number times full span
	assign top  = ((bf >> stage) << (stage + 1)) | pos;

	// W_span^pos expressed as a 16-point index
	assign tw_full = pos << (N_LOG2_MAX - 1 - stage);

	assign rd_en   = (state == RD);
	// Bottom word sits half a span above the top word
	assign rd_addr = cnt[0] ? (top | half) : top;
	assign rd_end  = rd_en && (cnt == A_W'(N-1));

	// Line up with the registered memory read data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pair_valid <= 1'b0;
		else
			pair_valid <= rd_en;
	end

	always_ff @(posedge clk)
	begin
		pair_addr <= rd_addr;
		tw_index  <= tw_full[A_W-2:0];
	end

	// Stage counter from the top stays inside the transform size
	a_stage_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state == RD) |-> (int'(stage) < N_LOG2));

endmodule

/* design/dft_butterfly.sv */
/*
 * Radix-2 DIT butterfly with conjugate twiddle multiply
 * Word a is held, b is rotated, then a+p and a-p come out
 * halved on consecutive cycles, 2 cycles after b arrives
 */

`timescale 1ns/1ns

module dft_butterfly (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic [dft_mem_pkg::A_W-1:0]   in_addr,
	input  logic [dft_mem_pkg::D_W-1:0]   in_re,
	input  logic [dft_mem_pkg::D_W-1:0]   in_im,
	input  logic [dft_mem_pkg::A_W-2:0]   tw_index,
	output logic                          out_valid,
	output logic [dft_mem_pkg::A_W-1:0]   out_addr,
	output logic [dft_mem_pkg::D_W-1:0]   out_re,
	output logic [dft_mem_pkg::D_W-1:0]   out_im
);
	import dft_mem_pkg::*;

	// High while word a is held and b is due
	logic                    phase;
	logic                    s1_valid;
	logic                    s2_valid;
	logic signed [D_W-1:0]   a_re;
	logic signed [D_W-1:0]   a_im;
	logic [A_W-1:0]          a_addr;
	logic [A_W-1:0]          b_addr;
	logic signed [TW_W-1:0]  tw_c;
	logic signed [TW_W-1:0]  tw_s;
	// Full precision products
	logic signed [2*D_W:0]   prod_re;
	logic signed [2*D_W:0]   prod_im;
	logic signed [D_W+3:0]   p_re;
	logic signed [D_W+3:0]   p_im;
	logic signed [D_W+3:0]   sum_re;
	logic signed [D_W+3:0]   sum_im;
	logic signed [D_W+3:0]   dif_re;
	logic signed [D_W+3:0]   dif_im;
	logic [D_W-1:0]          dif_re_q;
	logic [D_W-1:0]          dif_im_q;

	assign tw_c = twiddle_cos(tw_index);
	assign tw_s = twiddle_sin(tw_index);

	//----------------------------------------------------------------------
	// Control pipeline
	//----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase     <= 1'b0;
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			if (in_valid)
				phase <= ~phase;
			s1_valid  <= in_valid && phase;
			s2_valid  <= s1_valid;
			// Sum on s1, difference on s2
			out_valid <= s1_valid || s2_valid;
		end
	end

	//----------------------------------------------------------------------
	// Datapath
	//----------------------------------------------------------------------
	// Drop the Q1.14 fraction, floor rounding
	assign p_re   = (D_W+4)'(prod_re >>> (TW_W - 2));
	assign p_im   = (D_W+4)'(prod_im >>> (TW_W - 2));
	assign sum_re = a_re + p_re;
	assign sum_im = a_im + p_im;
	assign dif_re = a_re - p_re;
	assign dif_im = a_im - p_im;

	always_ff @(posedge clk)
	begin
		if (in_valid && !phase)
		begin
			a_re   <= $signed(in_re);
			a_im   <= $signed(in_im);
			a_addr <= in_addr;
		end
		// b * (cos - j sin)
		if (in_valid && phase)
		begin
			prod_re <= $signed(in_re) * tw_c + $signed(in_im) * tw_s;
			prod_im <= $signed(in_im) * tw_c - $signed(in_re) * tw_s;
			b_addr  <= in_addr;
		end
		// Halve by dropping bit 0
		if (s1_valid)
		begin
			out_re   <= sum_re[D_W:1];
			out_im   <= sum_im[D_W:1];
			out_addr <= a_addr;
			dif_re_q <= dif_re[D_W:1];
			dif_im_q <= dif_im[D_W:1];
		end
		else
		begin
			out_re   <= dif_re_q;
			out_im   <= dif_im_q;
			out_addr <= b_addr;
		end
	end

	// Words arrive as whole a,b pairs on adjacent cycles
	a_whole_pairs: assert property (@(posedge clk) disable iff (!rst_n)
		(in_valid && !phase) |=> in_valid);

endmodule

/* design/dft_stage_write.sv */
/*
 * Write stage of one radix-2 butterfly pass
 * Puts butterfly results back at their own addresses and
 * flags the Nth write of the stage
 */

`timescale 1ns/1ns

module dft_stage_write #(
	parameter int N_LOG2 = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  dft_mem_pkg::engine_state_t    state,
	input  logic                          in_valid,
	input  logic [dft_mem_pkg::A_W-1:0]   in_addr,
	input  logic [dft_mem_pkg::D_W-1:0]   in_re,
	input  logic [dft_mem_pkg::D_W-1:0]   in_im,
	output logic                          wr_en,
	output logic [dft_mem_pkg::A_W-1:0]   wr_addr,
	output logic [dft_mem_pkg::D_W-1:0]   wr_re,
	output logic [dft_mem_pkg::D_W-1:0]   wr_im,
	output logic                          wr_end
);
	import dft_mem_pkg::*;

	localparam int N = 1 << N_LOG2;

	engine_state_t  state_q;
	logic [A_W-1:0] cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= IDLE;
			cnt     <= '0;
			wr_en   <= 1'b0;
			wr_end  <= 1'b0;
		end
		else
		begin
			state_q <= state;
			wr_en   <= in_valid;
			// Pulses together with the Nth write
			wr_end  <= in_valid && (cnt == A_W'(N-1));
			// New stage starts on entry to RD
			if (state == RD && state_q != RD)
				cnt <= '0;
			else if (in_valid)
				cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		wr_addr <= in_addr;
		wr_re   <= in_re;
		wr_im   <= in_im;
	end

	// Butterfly results only appear during a pass
	a_wr_in_pass: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (state == RD || state == WAIT_WR_END));

endmodule

/* design/dft_mem_source.sv */
/*
 * Output source of the DFT engine
 * Reads the memory in natural order and streams N words
 * with out_sop on the first and source_end on the last
 */

`timescale 1ns/1ns

module dft_mem_source #(
	parameter int N_LOG2 = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          active,
	output logic                          rd_en,
	output logic [dft_mem_pkg::A_W-1:0]   rd_addr,
	input  logic [dft_mem_pkg::D_W-1:0]   rd_re,
	input  logic [dft_mem_pkg::D_W-1:0]   rd_im,
	output logic                          out_sop,
	output logic                          out_valid,
	output logic [dft_mem_pkg::D_W-1:0]   out_re,
	output logic [dft_mem_pkg::D_W-1:0]   out_im,
	output logic                          source_end
);
	import dft_mem_pkg::*;

	localparam int N = 1 << N_LOG2;

	// Counts to N and stops there
	logic [A_W:0]   cnt;
	logic           rd_q;
	logic [A_W-1:0] addr_q;

	assign rd_en   = active && (cnt < (A_W+1)'(N));
	assign rd_addr = cnt[A_W-1:0];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt        <= '0;
			rd_q       <= 1'b0;
			out_valid  <= 1'b0;
			out_sop    <= 1'b0;
			source_end <= 1'b0;
		end
		else
		begin
			if (!active)
				cnt <= '0;
			else if (rd_en)
				cnt <= cnt + 1'b1;
			// Memory data valid one cycle after the read
			rd_q       <= rd_en;
			out_valid  <= rd_q;
			out_sop    <= rd_q && (addr_q == '0);
			source_end <= rd_q && (addr_q == A_W'(N-1));
		end
	end

	always_ff @(posedge clk)
	begin
		addr_q <= rd_addr;
		out_re <= rd_re;
		out_im <= rd_im;
	end

	// SOURCE is left only after the last word goes out
	a_leave_after_end: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(active) |-> $past(source_end));

endmodule

/* design/dft_mem_top.sv */
/*
 * In-place radix-2 DFT engine around one shared memory
 * Engine FSM runs sink, N_LOG2 butterfly passes and source,
 * output is the DFT scaled by 1/N
 */

`timescale 1ns/1ns

module dft_mem_top #(
	parameter int N_LOG2 = 3
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_sop,
	input  logic                          in_valid,
	input  logic [dft_mem_pkg::D_W-1:0]   in_re,
	input  logic [dft_mem_pkg::D_W-1:0]   in_im,
	output logic                          sink_ready,
	output logic                          out_sop,
	output logic                          out_valid,
	output logic [dft_mem_pkg::D_W-1:0]   out_re,
	output logic [dft_mem_pkg::D_W-1:0]   out_im
);
	import dft_mem_pkg::*;

	engine_state_t                  state;
	logic [$clog2(N_LOG2_MAX)-1:0]  stage;
	logic                           sink_active;
	logic                           source_active;

	// Sink side
	logic           sk_wr_en;
	logic [A_W-1:0] sk_wr_addr;
	logic [D_W-1:0] sk_wr_re;
	logic [D_W-1:0] sk_wr_im;
	logic           sink_done;

	// Butterfly pass
	logic           rs_rd_en;
	logic [A_W-1:0] rs_rd_addr;
	logic           pair_valid;
	logic [A_W-1:0] pair_addr;
	logic [A_W-2:0] tw_index;
	logic           rd_end;
	logic           bf_valid;
	logic [A_W-1:0] bf_addr;
	logic [D_W-1:0] bf_re;
	logic [D_W-1:0] bf_im;
	logic           sw_wr_en;
	logic [A_W-1:0] sw_wr_addr;
	logic [D_W-1:0] sw_wr_re;
	logic [D_W-1:0] sw_wr_im;
	logic           wr_end;

	// Source side
	logic           so_rd_en;
	logic [A_W-1:0] so_rd_addr;
	logic           source_end;

	// Shared memory ports
	logic           wr_en;
	logic [A_W-1:0] wr_addr;
	logic [D_W-1:0] wr_re;
	logic [D_W-1:0] wr_im;
	logic           rd_en;
	logic [A_W-1:0] rd_addr;
	logic [D_W-1:0] rd_re;
	logic [D_W-1:0] rd_im;

	//----------------------------------------------------------------------
	// Engine FSM and stage counter
	//----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			stage <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					stage <= '0;
					if (in_valid && in_sop)
						state <= SINK;
				end
				SINK:
					if (sink_done)
						state <= RD;
				RD:
					if (rd_end)
						state <= WAIT_WR_END;
				WAIT_WR_END:
					if (wr_end)
					begin
						// Last pass goes straight to output
						if (int'(stage) == N_LOG2 - 1)
							state <= SOURCE;
						else
						begin
							state <= RD;
							stage <= stage + 1'b1;
						end
					end
				SOURCE:
					if (source_end)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	assign sink_ready    = (state == IDLE);
	// First sample is taken while still in IDLE
	assign sink_active   = (state == IDLE) || (state == SINK);
	assign source_active = (state == SOURCE);

	//----------------------------------------------------------------------
	// Memory port multiplexers
	//----------------------------------------------------------------------
	assign wr_en   = sink_active ? sk_wr_en   : sw_wr_en;
	assign wr_addr = sink_active ? sk_wr_addr : sw_wr_addr;
	assign wr_re   = sink_active ? sk_wr_re   : sw_wr_re;
	assign wr_im   = sink_active ? sk_wr_im   : sw_wr_im;

	assign rd_en   = source_active ? so_rd_en   : rs_rd_en;
	assign rd_addr = source_active ? so_rd_addr : rs_rd_addr;

	dft_bank_ram u_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_re   (wr_re),
		.wr_im   (wr_im),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_re   (rd_re),
		.rd_im   (rd_im)
	);

	dft_mem_sink #(.N_LOG2(N_LOG2)) u_sink (
		.clk       (clk),
		.rst_n     (rst_n),
		.active    (sink_active),
		.in_sop    (in_sop),
		.in_valid  (in_valid),
		.in_re     (in_re),
		.in_im     (in_im),
		.wr_en     (sk_wr_en),
		.wr_addr   (sk_wr_addr),
		.wr_re     (sk_wr_re),
		.wr_im     (sk_wr_im),
		.sink_done (sink_done)
	);

	dft_stage_read #(.N_LOG2(N_LOG2)) u_stage_read (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.stage      (stage),
		.rd_en      (rs_rd_en),
		.rd_addr    (rs_rd_addr),
		.pair_valid (pair_valid),
		.pair_addr  (pair_addr),
		.tw_index   (tw_index),
		.rd_end     (rd_end)
	);

	dft_butterfly u_butterfly (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (pair_valid),
		.in_addr   (pair_addr),
		.in_re     (rd_re),
		.in_im     (rd_im),
		.tw_index  (tw_index),
		.out_valid (bf_valid),
		.out_addr  (bf_addr),
		.out_re    (bf_re),
		.out_im    (bf_im)
	);

	dft_stage_write #(.N_LOG2(N_LOG2)) u_stage_write (
		.clk      (clk),
		.rst_n    (rst_n),
		.state    (state),
		.in_valid (bf_valid),
		.in_addr  (bf_addr),
		.in_re    (bf_re),
		.in_im    (bf_im),
		.wr_en    (sw_wr_en),
		.wr_addr  (sw_wr_addr),
		.wr_re    (sw_wr_re),
		.wr_im    (sw_wr_im),
		.wr_end   (wr_end)
	);

	dft_mem_source #(.N_LOG2(N_LOG2)) u_source (
		.clk        (clk),
		.rst_n      (rst_n),
		.active     (source_active),
		.rd_en      (so_rd_en),
		.rd_addr    (so_rd_addr),
		.rd_re      (rd_re),
		.rd_im      (rd_im),
		.out_sop    (out_sop),
		.out_valid  (out_valid),
		.out_re     (out_re),
		.out_im     (out_im),
		.source_end (source_end)
	);

	// Sink and pass writes never overlap
	a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
		!(sk_wr_en && sw_wr_en));

endmodule

/* testbench/tb_dft_mem_top.sv */
/*
 * Testbench for the in-place radix-2 DFT engine
 * Drives frames from the pattern file, checks outputs,
 * framing, reset values and busy rejection
 */

`timescale 1ns/1ns

module tb_dft_mem_top;
	import dft_mem_pkg::*;

	localparam int N_LOG2 = 3;
	localparam int N = 1 << N_LOG2;
	localparam int FRAMES_IN_FILE = 4;
	// Frames actually run, one file frame is sent twice
	localparam int FRAMES_RUN = 5;
	localparam int CYCLE_LIMIT = FRAMES_RUN * (4*N + N_LOG2*(N + 8) + N + 8) + 200;
	localparam logic [31:0] RAND_SEED = 32'h917b6d85;

	logic           clk;
	logic           rst_n;
	logic           in_sop;
	logic           in_valid;
	logic [D_W-1:0] in_re;
	logic [D_W-1:0] in_im;
	logic           sink_ready;
	logic           out_sop;
	logic           out_valid;
	logic [D_W-1:0] out_re;
	logic [D_W-1:0] out_im;

	// Four words per line: in_re, in_im, exp_re, exp_im
	logic [D_W-1:0] patterns [0:FRAMES_IN_FILE*N*4-1];

	int errors;
	int tests_passed;
	int tests_failed;
	int cycles;

	dft_mem_top #(.N_LOG2(N_LOG2)) u_dft_mem_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_sop     (in_sop),
		.in_valid   (in_valid),
		.in_re      (in_re),
		.in_im      (in_im),
		.sink_ready (sink_ready),
		.out_sop    (out_sop),
		.out_valid  (out_valid),
		.out_re     (out_re),
		.out_im     (out_im)
	);

	// 40 ns clock
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Watchdog on total run length
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles without finishing", cycles);
		$display("=== FAIL ===");
		$finish;
	end

	//----------------------------------------------------------------------
	// Check helpers
	//----------------------------------------------------------------------
	task automatic check_word(input string sig, input int frame, input int word,
		input logic [D_W-1:0] expected, input logic [D_W-1:0] actual);
		if (expected !== actual)
		begin
			$display("MISMATCH t=%0t %s frame %0d word %0d expected %h actual %h",
				$time, sig, frame, word, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string sig, input logic expected, input logic actual);
		if (expected !== actual)
		begin
			$display("MISMATCH t=%0t %s expected %b actual %b", $time, sig, expected, actual);
			errors++;
		end
	endtask

	task automatic report_fault(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			$display("test %s: passed", name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	//----------------------------------------------------------------------
	// Stimulus and response
	//----------------------------------------------------------------------
	// One frame in, optional random gaps, optional junk while busy
	task automatic send_frame(input int f, input bit with_gaps, input bit with_junk);
		int gap;
		int base;
		@(posedge clk);
		while (sink_ready !== 1'b1)
			@(posedge clk);
		for (int n = 0; n < N; n++)
		begin
			base = (f*N + n) * 4;
			gap = with_gaps ? int'($urandom % 4) : 0;
			repeat (gap)
			begin
				@(posedge clk);
				in_valid <= 1'b0;
				in_sop   <= 1'b0;
			end
			@(posedge clk);
			in_valid <= 1'b1;
			in_sop   <= (n == 0);
			in_re    <= patterns[base];
			in_im    <= patterns[base + 1];
		end
		// Engine is now past the sink, extra samples must be dropped
		if (with_junk)
		begin
			for (int j = 0; j < 6; j++)
			begin
				@(posedge clk);
				if (sink_ready !== 1'b0)
					report_fault("sink_ready high while the engine is busy");
				in_valid <= 1'b1;
				in_sop   <= (j == 0) || (j == 3);
				in_re    <= D_W'($urandom);
				in_im    <= D_W'($urandom);
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
	endtask

	// N consecutive words, sop on the first only
	task automatic collect_frame(input int f);
		int base;
		int idle_cycles;
		@(posedge clk);
		while (out_valid !== 1'b1)
			@(posedge clk);
		for (int k = 0; k < N; k++)
		begin
			base = (f*N + k) * 4;
			if (k > 0)
				@(posedge clk);
			if (out_valid !== 1'b1)
				report_fault("out_valid dropped inside an output frame");
			else
			begin
				check_bit("out_sop", (k == 0), out_sop);
				check_word("out_re", f, k, patterns[base + 2], out_re);
				check_word("out_im", f, k, patterns[base + 3], out_im);
			end
		end
		// Back to IDLE right after the last word
		idle_cycles = 0;
		@(posedge clk);
		while (sink_ready !== 1'b1 && idle_cycles < 4)
		begin
			if (out_valid !== 1'b0)
				report_fault("extra out_valid after a full output frame");
			idle_cycles++;
			@(posedge clk);
		end
		if (out_valid !== 1'b0)
			report_fault("extra out_valid after a full output frame");
		if (sink_ready !== 1'b1)
			report_fault("sink_ready did not return high after the last output");
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial
	begin
		int errs;
		int seed_value;
		seed_value   = $urandom(RAND_SEED);
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		rst_n    = 1'b0;
		in_sop   = 1'b0;
		in_valid = 1'b0;
		in_re    = '0;
		in_im    = '0;
		$readmemh("testbench/dft_patterns.txt", patterns);

		// Reset values, first edge only loads the reset
		errs = errors;
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk);
			if (i > 0)
			begin
				check_bit("sink_ready", 1'b1, sink_ready);
				check_bit("out_valid", 1'b0, out_valid);
				check_bit("out_sop", 1'b0, out_sop);
			end
		end
		rst_n <= 1'b1;
		repeat (2)
		begin
			@(posedge clk);
			check_bit("sink_ready", 1'b1, sink_ready);
			check_bit("out_valid", 1'b0, out_valid);
			check_bit("out_sop", 1'b0, out_sop);
		end
		finish_test("reset", errs);

		// Impulse and DC back to back
		errs = errors;
		send_frame(0, 1'b0, 1'b0);
		collect_frame(0);
		finish_test("impulse frame", errs);

		errs = errors;
		send_frame(1, 1'b0, 1'b0);
		collect_frame(1);
		finish_test("dc frame", errs);

		// Mixed data with input gaps
		errs = errors;
		send_frame(2, 1'b1, 1'b0);
		collect_frame(2);
		finish_test("data frame with gaps a", errs);

		errs = errors;
		send_frame(3, 1'b1, 1'b0);
		collect_frame(3);
		finish_test("data frame with gaps b", errs);

		// Same data again, junk and a stray sop while busy
		errs = errors;
		send_frame(2, 1'b1, 1'b1);
		collect_frame(2);
		finish_test("busy rejection", errs);

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* sources.f */
design/dft_mem_pkg.sv
design/dft_bank_ram.sv
design/dft_mem_sink.sv
design/dft_stage_read.sv
design/dft_butterfly.sv
design/dft_stage_write.sv
design/dft_mem_source.sv
design/dft_mem_top.sv
testbench/tb_dft_mem_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the DFT engine testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_dft_mem_top -o tb_dft_mem_top || exit 1
result=$(./obj_dir/tb_dft_mem_top)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx '=== PASS ===' && exit 0 || exit 1

/* testbench/dft_patterns.txt */
// Columns: in_re in_im exp_re exp_im, 16-bit two's complement hex
// 8 lines per frame, expected output in natural order, DFT scaled by 1/8
// frame 0, impulse
1000 0000 0200 0000
0000 0000 0200 0000
0000 0000 0200 0000
0000 0000 0200 0000
0000 0000 0200 0000
0000 0000 0200 0000
0000 0000 0200 0000
0000 0000 0200 0000
// frame 1, DC
0640 FE70 0640 FE70
0640 FE70 0000 0000
0640 FE70 0000 0000
0640 FE70 0000 0000
0640 FE70 0000 0000
0640 FE70 0000 0000
0640 FE70 0000 0000
0640 FE70 0000 0000
// frame 2, small mixed data
0064 0005 0011 0006
FFCE 0000 0003 0001
001E FFF8 0002 0005
0007 000C 001A 0007
FFEC 0028 000D 0002
0040 FFFF 0019 FFF0
000B 0000 0008 0007
FFFD 0009 0005 FFF4
// frame 3, larger mixed data
FC18 012C 001C 0076
00FA FED4 FE8F FF2B
0000 004D 00D0 0031
014D 0000 FE7A 00C8
04B0 FFFB FF76 FFE7
FFF9 03E8 FF5D 0080
FD80 0002 0001 0004
005A FF80 FF4D 0024
